/* common/excp_config.svh */
`ifndef EXCP_CONFIG_SVH
`define EXCP_CONFIG_SVH

`define EXCP_XLEN 32

// interrupt vector layout is swi 1:0, hwi 9:2, timer 11
`define EXCP_INT_NUM 13
`define EXCP_HWI_NUM 8
`define EXCP_SWI_NUM 2

// page number comes from address bits 31:13
`define EXCP_VPPN_W 19

// entry points must stay 64-byte aligned
`define EXCP_EENTRY_RST 32'h1c00_8000
`define EXCP_TLBRENTRY_RST 32'h1c00_f000

`endif

/* common/excp_pkg.sv */
`default_nettype none

package excp_pkg;

    // 6-bit exception codes as recorded in estat
    typedef enum logic [5:0] {
        INT  = 6'h00,
        PIL  = 6'h01,
        PIS  = 6'h02,
        PIF  = 6'h03,
        PME  = 6'h04,
        PPI  = 6'h07,
        ADEF = 6'h08,
        ALE  = 6'h09,
        ADEM = 6'h0a,
        SYS  = 6'h0b,
        BRK  = 6'h0c,
        INE  = 6'h0d,
        TLBR = 6'h3f   // refill gets its own entry point
    } ecode_t;

    typedef enum logic [1:0] {
        KERNEL = 2'd0,
        USER   = 2'd3
    } plv_t;

    // addresses of the registers that software can write
    typedef enum logic [4:0] {
        CRMD      = 5'h00,
        PRMD      = 5'h01,
        ECFG      = 5'h04,
        ESTAT     = 5'h05,
        ERA       = 5'h06,
        BADV      = 5'h07,
        EENTRY    = 5'h0c,
        TLBEHI    = 5'h11,
        TLBRENTRY = 5'h18
    } csr_addr_t;

endpackage

`default_nettype wire

/* design/int_pending.sv */
`timescale 1ns/1ps
`default_nettype none

`include "excp_config.svh"

module int_pending (
    input  wire logic                        clk,
    input  wire logic                        rst_n,
    input  wire logic [`EXCP_HWI_NUM-1:0]    hwi,
    input  wire logic                        ti,
    input  wire logic                        ti_clr,
    input  wire logic [`EXCP_SWI_NUM-1:0]    swi_set,
    input  wire logic [`EXCP_SWI_NUM-1:0]    swi_clr,
    output logic      [`EXCP_INT_NUM-1:0]    int_status
);

    logic [`EXCP_INT_NUM-1:0] int_req;
    logic [`EXCP_INT_NUM-1:0] int_clr;
    logic [`EXCP_INT_NUM-1:0] pend_q;

    // bits 10 and 12 are reserved and never set
    assign int_req = {1'b0, ti, 1'b0, hwi, swi_set};
    assign int_clr = {1'b0, ti_clr, 1'b0, {`EXCP_HWI_NUM{1'b0}}, swi_clr};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pend_q     <= '0;
            int_status <= '0;
        end else begin
            // a clear wins over a request arriving in the same cycle
            pend_q     <= ~int_clr & (int_req | pend_q);
            int_status <= pend_q;   // second stage only retimes
        end
    end

endmodule

`default_nettype wire

/* exception/excp_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module excp_decode (
    input  wire excp_pkg::ecode_t excp_code,
    output logic                  is_tlbr,
    output logic                  wr_badv,
    output logic                  wr_vppn
);

    import excp_pkg::*;

    always_comb begin
        is_tlbr = 1'b0;
        wr_badv = 1'b0;
        wr_vppn = 1'b0;
        case (excp_code)
            TLBR: begin
                is_tlbr = 1'b1;
                wr_badv = 1'b1;
                wr_vppn = 1'b1;
            end
            // page faults report both the address and its page
            PIL, PIS, PIF, PME, PPI: begin
                wr_badv = 1'b1;
                wr_vppn = 1'b1;
            end
            ADEF, ADEM, ALE: begin
                wr_badv = 1'b1;   // no translation involved so the page is left alone
            end
            default: begin
                is_tlbr = 1'b0;
                wr_badv = 1'b0;
                wr_vppn = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* exception/excp_commit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "excp_config.svh"

module excp_commit (
    input  wire logic                      commit_valid,
    input  wire logic [`EXCP_XLEN-1:0]     commit_pc,
    input  wire logic                      excp_valid,
    input  wire excp_pkg::ecode_t          excp_code,
    input  wire logic [`EXCP_XLEN-1:0]     excp_badv,
    input  wire logic                      is_tlbr,
    input  wire logic                      wr_badv,
    input  wire logic                      wr_vppn,
    input  wire logic [`EXCP_INT_NUM-1:0]  int_status,
    input  wire excp_pkg::plv_t            crmd_plv,
    input  wire logic                      crmd_ie,
    input  wire logic [`EXCP_INT_NUM-1:0]  lie,
    input  wire logic [`EXCP_XLEN-1:0]     eentry,
    input  wire logic [`EXCP_XLEN-1:0]     tlbrentry,
    output logic                           redirect_valid,
    output logic      [`EXCP_XLEN-1:0]     redirect_pc,
    output logic                           excp_flush,
    output logic                           int_wake,
    output logic                           upd_we,
    output excp_pkg::plv_t                 upd_plv,
    output logic                           upd_ie,
    output excp_pkg::plv_t                 upd_pplv,
    output logic                           upd_pie,
    output logic                           upd_da_pg,
    output logic      [`EXCP_XLEN-1:0]     upd_era,
    output excp_pkg::ecode_t               upd_ecode,
    output logic                           upd_badv_we,
    output logic      [`EXCP_XLEN-1:0]     upd_badv,
    output logic                           upd_vppn_we,
    output logic      [`EXCP_VPPN_W-1:0]   upd_vppn
);

    import excp_pkg::*;

    logic int_pend;
    logic take_int;
    logic take_excp;

    // wake-up does not wait for a commit
    assign int_pend  = crmd_ie & (|(int_status & lie));
    assign int_wake  = int_pend;
    assign take_int  = commit_valid & int_pend;
    assign take_excp = commit_valid & excp_valid & ~take_int;   // interrupts take priority

    assign upd_we         = take_int | take_excp;
    assign redirect_valid = upd_we;
    assign excp_flush     = upd_we;
    assign redirect_pc    = (take_excp & is_tlbr) ? tlbrentry : eentry;

    always_comb begin
        upd_plv  = KERNEL;
        upd_ie   = 1'b0;
        upd_pplv = crmd_plv;
        upd_pie  = crmd_ie;
        upd_era  = commit_pc;
        if (take_int) begin
            upd_ecode = INT;
        end else begin
            upd_ecode = excp_code;
        end
    end

    // refill runs with translation off
    assign upd_da_pg   = take_excp & is_tlbr;
    assign upd_badv_we = take_excp & wr_badv;
    assign upd_badv    = excp_badv;
    assign upd_vppn_we = take_excp & wr_vppn;
    assign upd_vppn    = excp_badv[`EXCP_XLEN-1 -: `EXCP_VPPN_W];

endmodule

`default_nettype wire

/* csr/csr_file.sv */
`timescale 1ns/1ps
`default_nettype none

`include "excp_config.svh"

module csr_file (
    input  wire logic                      clk,
    input  wire logic                      rst_n,
    input  wire logic                      csr_we,
    input  wire excp_pkg::csr_addr_t       csr_addr,
    input  wire logic [`EXCP_XLEN-1:0]     csr_wdata,
    input  wire logic                      upd_we,
    input  wire excp_pkg::plv_t            upd_plv,
    input  wire logic                      upd_ie,
    input  wire excp_pkg::plv_t            upd_pplv,
    input  wire logic                      upd_pie,
    input  wire logic                      upd_da_pg,
    input  wire logic [`EXCP_XLEN-1:0]     upd_era,
    input  wire excp_pkg::ecode_t          upd_ecode,
    input  wire logic                      upd_badv_we,
    input  wire logic [`EXCP_XLEN-1:0]     upd_badv,
    input  wire logic                      upd_vppn_we,
    input  wire logic [`EXCP_VPPN_W-1:0]   upd_vppn,
    output excp_pkg::plv_t                 crmd_plv,
    output logic                           crmd_ie,
    output logic                           crmd_da,
    output logic                           crmd_pg,
    output excp_pkg::plv_t                 prmd_pplv,
    output logic                           prmd_pie,
    output logic      [`EXCP_INT_NUM-1:0]  lie,
    output excp_pkg::ecode_t               estat_ecode,
    output logic      [`EXCP_XLEN-1:0]     era,
    output logic      [`EXCP_XLEN-1:0]     badv,
    output logic      [`EXCP_VPPN_W-1:0]   tlbehi_vppn,
    output logic      [`EXCP_XLEN-1:0]     eentry,
    output logic      [`EXCP_XLEN-1:0]     tlbrentry
);

    import excp_pkg::*;

    // reserved interrupt bits 10 and 12 cannot be enabled
    localparam logic [`EXCP_INT_NUM-1:0] LIE_MASK = 13'h0bff;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            crmd_plv  <= KERNEL;
            crmd_ie   <= 1'b0;
            crmd_da   <= 1'b1;
            crmd_pg   <= 1'b0;
            prmd_pplv <= KERNEL;
            prmd_pie  <= 1'b0;
            lie       <= '0;
            eentry    <= `EXCP_EENTRY_RST;
            tlbrentry <= `EXCP_TLBRENTRY_RST;
        end else begin
            if (csr_we) begin
                case (csr_addr)
                    CRMD: begin
                        crmd_plv <= plv_t'(csr_wdata[1:0]);
                        crmd_ie  <= csr_wdata[2];
                        crmd_da  <= csr_wdata[3];
                        crmd_pg  <= csr_wdata[4];
                    end
                    PRMD: begin
                        prmd_pplv <= plv_t'(csr_wdata[1:0]);
                        prmd_pie  <= csr_wdata[2];
                    end
                    ECFG:      lie       <= csr_wdata[`EXCP_INT_NUM-1:0] & LIE_MASK;
                    EENTRY:    eentry    <= {csr_wdata[`EXCP_XLEN-1:6], 6'b0};
                    TLBRENTRY: tlbrentry <= {csr_wdata[`EXCP_XLEN-1:6], 6'b0};
                    default: ;
                endcase
            end
            // the commit update comes last so it overrides a software write
            if (upd_we) begin
                crmd_plv  <= upd_plv;
                crmd_ie   <= upd_ie;
                prmd_pplv <= upd_pplv;
                prmd_pie  <= upd_pie;
                if (upd_da_pg) begin
                    crmd_da <= 1'b1;
                    crmd_pg <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (csr_we) begin
            case (csr_addr)
                ESTAT:  estat_ecode <= ecode_t'(csr_wdata[21:16]);
                ERA:    era         <= csr_wdata;
                BADV:   badv        <= csr_wdata;
                TLBEHI: tlbehi_vppn <= csr_wdata[`EXCP_XLEN-1 -: `EXCP_VPPN_W];
                default: ;
            endcase
        end
        if (upd_we) begin
            era         <= upd_era;
            estat_ecode <= upd_ecode;
        end
        if (upd_badv_we) begin
            badv <= upd_badv;
        end
        if (upd_vppn_we) begin
            tlbehi_vppn <= upd_vppn;
        end
    end

endmodule

`default_nettype wire

/* design/excp_unit_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "excp_config.svh"

module excp_unit_top (
    input  wire logic                      clk,
    input  wire logic                      rst_n,
    input  wire logic                      commit_valid,
    input  wire logic [`EXCP_XLEN-1:0]     commit_pc,
    input  wire logic                      excp_valid,
    input  wire excp_pkg::ecode_t          excp_code,
    input  wire logic [`EXCP_XLEN-1:0]     excp_badv,
    input  wire logic                      csr_we,
    input  wire excp_pkg::csr_addr_t       csr_addr,
    input  wire logic [`EXCP_XLEN-1:0]     csr_wdata,
    input  wire logic [`EXCP_HWI_NUM-1:0]  hwi,
    input  wire logic                      ti,
    input  wire logic [`EXCP_SWI_NUM-1:0]  swi_set,
    input  wire logic [`EXCP_SWI_NUM-1:0]  swi_clr,
    input  wire logic                      ti_clr,
    output logic                           redirect_valid,
    output logic      [`EXCP_XLEN-1:0]     redirect_pc,
    output logic                           excp_flush,
    output logic                           int_wake,
    output logic      [`EXCP_INT_NUM-1:0]  int_status,
    output excp_pkg::plv_t                 crmd_plv,
    output logic                           crmd_ie,
    output logic                           crmd_da,
    output logic                           crmd_pg,
    output excp_pkg::plv_t                 prmd_pplv,
    output logic                           prmd_pie,
    output logic      [`EXCP_INT_NUM-1:0]  lie,
    output excp_pkg::ecode_t               estat_ecode,
    output logic      [`EXCP_XLEN-1:0]     era,
    output logic      [`EXCP_XLEN-1:0]     badv,
    output logic      [`EXCP_VPPN_W-1:0]   tlbehi_vppn,
    output logic      [`EXCP_XLEN-1:0]     eentry,
    output logic      [`EXCP_XLEN-1:0]     tlbrentry
);

    import excp_pkg::*;

    logic                      is_tlbr;
    logic                      wr_badv;
    logic                      wr_vppn;
    logic                      upd_we;
    plv_t                      upd_plv;
    logic                      upd_ie;
    plv_t                      upd_pplv;
    logic                      upd_pie;
    logic                      upd_da_pg;
    logic [`EXCP_XLEN-1:0]     upd_era;
    ecode_t                    upd_ecode;
    logic                      upd_badv_we;
    logic [`EXCP_XLEN-1:0]     upd_badv;
    logic                      upd_vppn_we;
    logic [`EXCP_VPPN_W-1:0]   upd_vppn;

    int_pending i_int_pending (
        .clk        (clk),
        .rst_n      (rst_n),
        .hwi        (hwi),
        .ti         (ti),
        .ti_clr     (ti_clr),
        .swi_set    (swi_set),
        .swi_clr    (swi_clr),
        .int_status (int_status)
    );

    excp_decode i_excp_decode (
        .excp_code (excp_code),
        .is_tlbr   (is_tlbr),
        .wr_badv   (wr_badv),
        .wr_vppn   (wr_vppn)
    );

    // commit reads the live register state and returns the update set
    excp_commit i_excp_commit (
        .commit_valid   (commit_valid),
        .commit_pc      (commit_pc),
        .excp_valid     (excp_valid),
        .excp_code      (excp_code),
        .excp_badv      (excp_badv),
        .is_tlbr        (is_tlbr),
        .wr_badv        (wr_badv),
        .wr_vppn        (wr_vppn),
        .int_status     (int_status),
        .crmd_plv       (crmd_plv),
        .crmd_ie        (crmd_ie),
        .lie            (lie),
        .eentry         (eentry),
        .tlbrentry      (tlbrentry),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .excp_flush     (excp_flush),
        .int_wake       (int_wake),
        .upd_we         (upd_we),
        .upd_plv        (upd_plv),
        .upd_ie         (upd_ie),
        .upd_pplv       (upd_pplv),
        .upd_pie        (upd_pie),
        .upd_da_pg      (upd_da_pg),
        .upd_era        (upd_era),
        .upd_ecode      (upd_ecode),
        .upd_badv_we    (upd_badv_we),
        .upd_badv       (upd_badv),
        .upd_vppn_we    (upd_vppn_we),
        .upd_vppn       (upd_vppn)
    );

    csr_file i_csr_file (
        .clk         (clk),
        .rst_n       (rst_n),
        .csr_we      (csr_we),
        .csr_addr    (csr_addr),
        .csr_wdata   (csr_wdata),
        .upd_we      (upd_we),
        .upd_plv     (upd_plv),
        .upd_ie      (upd_ie),
        .upd_pplv    (upd_pplv),
        .upd_pie     (upd_pie),
        .upd_da_pg   (upd_da_pg),
        .upd_era     (upd_era),
        .upd_ecode   (upd_ecode),
        .upd_badv_we (upd_badv_we),
        .upd_badv    (upd_badv),
        .upd_vppn_we (upd_vppn_we),
        .upd_vppn    (upd_vppn),
        .crmd_plv    (crmd_plv),
        .crmd_ie     (crmd_ie),
        .crmd_da     (crmd_da),
        .crmd_pg     (crmd_pg),
        .prmd_pplv   (prmd_pplv),
        .prmd_pie    (prmd_pie),
        .lie         (lie),
        .estat_ecode (estat_ecode),
        .era         (era),
        .badv        (badv),
        .tlbehi_vppn (tlbehi_vppn),
        .eentry      (eentry),
        .tlbrentry   (tlbrentry)
    );

endmodule

`default_nettype wire

/* verification/tb_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD     = 8,
    parameter int RST_CYCLES = 8
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;   // released on a falling edge like every other input
    end

endmodule

`default_nettype wire

/* verification/tb_checker.sv */
`timescale 1ns/1ps
`default_nettype none

`include "excp_config.svh"

module tb_checker (
    input  wire logic                      clk,
    input  wire logic                      chk_comb,
    input  wire logic                      chk_regs,
    input  wire logic [95:0]               test_name,
    input  wire logic                      got_redir,
    input  wire logic                      got_flush,
    input  wire logic                      got_wake,
    input  wire logic [`EXCP_XLEN-1:0]     got_rpc,
    input  wire logic [`EXCP_INT_NUM-1:0]  got_int,
    input  wire logic                      exp_redir,
    input  wire logic                      exp_wake,
    input  wire logic [`EXCP_XLEN-1:0]     exp_rpc,
    input  wire logic [`EXCP_INT_NUM-1:0]  exp_int,
    input  wire logic [7:0]                got_mode,
    input  wire logic [7:0]                exp_mode,
    input  wire logic [`EXCP_INT_NUM-1:0]  got_lie,
    input  wire logic [`EXCP_INT_NUM-1:0]  exp_lie,
    input  wire logic [`EXCP_XLEN-1:0]     got_eentry,
    input  wire logic [`EXCP_XLEN-1:0]     exp_eentry,
    input  wire logic [`EXCP_XLEN-1:0]     got_tlbrentry,
    input  wire logic [`EXCP_XLEN-1:0]     exp_tlbrentry,
    input  wire logic [3:0]                exp_known,
    input  wire logic [5:0]                got_ecode,
    input  wire logic [5:0]                exp_ecode,
    input  wire logic [`EXCP_XLEN-1:0]     got_era,
    input  wire logic [`EXCP_XLEN-1:0]     exp_era,
    input  wire logic [`EXCP_XLEN-1:0]     got_badv,
    input  wire logic [`EXCP_XLEN-1:0]     exp_badv,
    input  wire logic [`EXCP_VPPN_W-1:0]   got_vppn,
    input  wire logic [`EXCP_VPPN_W-1:0]   exp_vppn,
    output int                             pass_count,
    output int                             fail_count
);

    logic row_bad = 1'b0;

    initial begin
        pass_count = 0;
        fail_count = 0;
    end

    task automatic compare(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("Fail %0t: %0s %0s got %h expected %h", $time, test_name, what, got, exp);
            row_bad = 1'b1;
        end
    endtask

    always @(posedge clk) begin
        // combinational outputs while the commit strobe is held
        if (chk_comb) begin
            compare("redirect_valid", got_redir, exp_redir);
            compare("excp_flush", got_flush, exp_redir);
            compare("int_wake", got_wake, exp_wake);
            compare("int_status", got_int, exp_int);
            if (exp_redir) begin
                compare("redirect_pc", got_rpc, exp_rpc);
            end
        end
        if (chk_regs) begin
            compare("crmd/prmd fields", got_mode, exp_mode);
            compare("lie", got_lie, exp_lie);
            compare("eentry", got_eentry, exp_eentry);
            compare("tlbrentry", got_tlbrentry, exp_tlbrentry);
            // era, badv, estat and vppn have no reset value until first written
            if (exp_known[3]) compare("estat ecode", got_ecode, exp_ecode);
            if (exp_known[2]) compare("era", got_era, exp_era);
            if (exp_known[1]) compare("badv", got_badv, exp_badv);
            if (exp_known[0]) compare("tlbehi vppn", got_vppn, exp_vppn);
            if (row_bad) begin
                fail_count = fail_count + 1;
                $display("%0s: mismatch", test_name);
            end else begin
                pass_count = pass_count + 1;
                $display("%0s: ok", test_name);
            end
            row_bad = 1'b0;
        end
    end

endmodule

`default_nettype wire

/* verification/tb_excp_unit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "excp_config.svh"

module tb_excp_unit;

    import excp_pkg::*;

    localparam int ROW_CYCLES = 4;
    localparam int RST_CYCLES = 8;

    typedef struct packed {
        logic [95:0]              name;
        logic                     wr_en;
        csr_addr_t                addr;
        logic [`EXCP_XLEN-1:0]    data;
        logic [`EXCP_INT_NUM-1:0] set;
        logic [`EXCP_INT_NUM-1:0] clr;
        logic [1:0]               cmt;     // commit_valid, excp_valid
        ecode_t                   code;
        logic [4:0]               flags;   // wake, redirect, refill entry, badv write, vppn write
        ecode_t                   ecode;
        logic [`EXCP_INT_NUM-1:0] ints;
    } row_t;

    logic clk;
    logic rst_n;
    logic commit_valid;
    logic [`EXCP_XLEN-1:0] commit_pc;
    logic excp_valid;
    ecode_t excp_code;
    logic [`EXCP_XLEN-1:0] excp_badv;
    logic csr_we;
    csr_addr_t csr_addr;
    logic [`EXCP_XLEN-1:0] csr_wdata;
    logic [`EXCP_HWI_NUM-1:0] hwi;
    logic ti;
    logic [`EXCP_SWI_NUM-1:0] swi_set;
    logic [`EXCP_SWI_NUM-1:0] swi_clr;
    logic ti_clr;
    logic redirect_valid;
    logic [`EXCP_XLEN-1:0] redirect_pc;
    logic excp_flush;
    logic int_wake;
    logic [`EXCP_INT_NUM-1:0] int_status;
    plv_t crmd_plv;
    logic crmd_ie;
    logic crmd_da;
    logic crmd_pg;
    plv_t prmd_pplv;
    logic prmd_pie;
    logic [`EXCP_INT_NUM-1:0] lie;
    ecode_t estat_ecode;
    logic [`EXCP_XLEN-1:0] era;
    logic [`EXCP_XLEN-1:0] badv;
    logic [`EXCP_VPPN_W-1:0] tlbehi_vppn;
    logic [`EXCP_XLEN-1:0] eentry;
    logic [`EXCP_XLEN-1:0] tlbrentry;

    // expected register state, kept from the rules of each row
    logic [1:0] m_plv;
    logic [1:0] m_pplv;
    logic m_ie;
    logic m_da;
    logic m_pg;
    logic m_pie;
    logic [`EXCP_INT_NUM-1:0] m_lie;
    logic [5:0] m_ecode;
    logic [`EXCP_XLEN-1:0] m_era;
    logic [`EXCP_XLEN-1:0] m_badv;
    logic [`EXCP_XLEN-1:0] m_eentry;
    logic [`EXCP_XLEN-1:0] m_tlbrentry;
    logic [`EXCP_VPPN_W-1:0] m_vppn;
    logic [3:0] m_known;   // ecode, era, badv, vppn

    row_t table_q[$];
    logic [31:0] lfsr = 32'hf5f4;
    int cycles = 0;
    int cycle_limit = 1000;
    int pass_count;
    int fail_count;
    logic chk_comb;
    logic chk_regs;
    logic exp_redir;
    logic exp_wake;
    logic [`EXCP_XLEN-1:0] exp_rpc;
    logic [`EXCP_INT_NUM-1:0] exp_int;
    logic [95:0] cur_name;

    tb_clock_gen #(.PERIOD(8), .RST_CYCLES(RST_CYCLES)) i_clock_gen (.clk(clk), .rst_n(rst_n));

    excp_unit_top i_dut (.*);

    tb_checker i_checker (
        .clk           (clk),
        .chk_comb      (chk_comb),
        .chk_regs      (chk_regs),
        .test_name     (cur_name),
        .got_redir     (redirect_valid),
        .got_flush     (excp_flush),
        .got_wake      (int_wake),
        .got_rpc       (redirect_pc),
        .got_int       (int_status),
        .exp_redir     (exp_redir),
        .exp_wake      (exp_wake),
        .exp_rpc       (exp_rpc),
        .exp_int       (exp_int),
        .got_mode      ({crmd_plv, crmd_ie, crmd_da, crmd_pg, prmd_pplv, prmd_pie}),
        .exp_mode      ({m_plv, m_ie, m_da, m_pg, m_pplv, m_pie}),
        .got_lie       (lie),
        .exp_lie       (m_lie),
        .got_eentry    (eentry),
        .exp_eentry    (m_eentry),
        .got_tlbrentry (tlbrentry),
        .exp_tlbrentry (m_tlbrentry),
        .exp_known     (m_known),
        .got_ecode     (estat_ecode),
        .exp_ecode     (m_ecode),
        .got_era       (era),
        .exp_era       (m_era),
        .got_badv      (badv),
        .exp_badv      (m_badv),
        .got_vppn      (tlbehi_vppn),
        .exp_vppn      (m_vppn),
        .pass_count    (pass_count),
        .fail_count    (fail_count)
    );

    // 32-bit Fibonacci LFSR with taps 32, 22, 2, 1 and one step per bit
    function automatic logic [31:0] next_word();
        logic [31:0] w;
        logic fb;
        w = '0;
        for (int i = 0; i < 32; i++) begin
            fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            w = {w[30:0], fb};
        end
        return w;
    endfunction

    task automatic add_row(input logic [95:0] name, input logic wr_en, input csr_addr_t addr,
                           input logic [31:0] data, input logic [12:0] set, input logic [12:0] clr,
                           input logic [1:0] cmt, input ecode_t code, input logic [4:0] flags,
                           input ecode_t ecode, input logic [12:0] ints);
        row_t r;
        r = '{name, wr_en, addr, data, set, clr, cmt, code, flags, ecode, ints};
        table_q.push_back(r);
    endtask

    task automatic build_table();
        add_row("w_eentry", 1, EENTRY, 32'h1c00_1000, '0, '0, 2'b00, INT, 5'b00000, INT, '0);
        add_row("w_tlbrentry", 1, TLBRENTRY, 32'h1c00_2040, '0, '0, 2'b00, INT, 5'b00000, INT, '0);
        add_row("w_tlbehi", 1, TLBEHI, 32'h0000_6000, '0, '0, 2'b00, INT, 5'b00000, INT, '0);
        add_row("w_crmd_a", 1, CRMD, 32'h17, '0, '0, 2'b00, INT, 5'b00000, INT, '0);
        add_row("excp_ale", 0, CRMD, '0, '0, '0, 2'b11, ALE, 5'b01010, ALE, '0);
        add_row("w_crmd_b", 1, CRMD, 32'h13, '0, '0, 2'b00, INT, 5'b00000, INT, '0);
        add_row("excp_sys", 0, CRMD, '0, '0, '0, 2'b11, SYS, 5'b01000, SYS, '0);
        add_row("w_crmd_c", 1, CRMD, 32'h17, '0, '0, 2'b00, INT, 5'b00000, INT, '0);
        add_row("excp_pif", 0, CRMD, '0, '0, '0, 2'b11, PIF, 5'b01011, PIF, '0);
        add_row("w_crmd_d", 1, CRMD, 32'h17, '0, '0, 2'b00, INT, 5'b00000, INT, '0);
        add_row("excp_tlbr", 0, CRMD, '0, '0, '0, 2'b11, TLBR, 5'b01111, TLBR, '0);
        add_row("w_ecfg_hwi0", 1, ECFG, 32'h004, '0, '0, 2'b00, INT, 5'b00000, INT, '0);
        add_row("w_crmd_ie", 1, CRMD, 32'h04, '0, '0, 2'b00, INT, 5'b00000, INT, '0);
        // the pending hwi line beats the ADEF that commits with it
        add_row("int_hwi0", 0, CRMD, '0, 13'h004, '0, 2'b11, ADEF, 5'b11000, INT, 13'h004);
        add_row("no_ie", 0, CRMD, '0, 13'h800, '0, 2'b10, INT, 5'b00000, INT, 13'h804);
        add_row("w_ecfg_zero", 1, ECFG, 32'h0, '0, '0, 2'b00, INT, 5'b00000, INT, 13'h804);
        add_row("w_crmd_ie2", 1, CRMD, 32'h04, '0, '0, 2'b00, INT, 5'b00000, INT, 13'h804);
        add_row("no_lie", 0, CRMD, '0, 13'h001, '0, 2'b10, INT, 5'b00000, INT, 13'h805);
        add_row("swi_hold", 0, CRMD, '0, '0, '0, 2'b00, INT, 5'b00000, INT, 13'h805);
        add_row("swi_ti_clr", 0, CRMD, '0, '0, 13'h801, 2'b00, INT, 5'b00000, INT, 13'h004);
    endtask

    task automatic model_write(input row_t r);
        if (r.wr_en) begin
            case (r.addr)
                CRMD:      {m_pg, m_da, m_ie, m_plv} = r.data[4:0];
                ECFG:      m_lie = r.data[`EXCP_INT_NUM-1:0];
                EENTRY:    m_eentry = r.data;
                TLBRENTRY: m_tlbrentry = r.data;
                TLBEHI: begin
                    m_vppn = r.data[31:13];
                    m_known[0] = 1'b1;
                end
                default: ;
            endcase
        end
    endtask

    task automatic model_commit(input row_t r, input logic [31:0] pc, input logic [31:0] bad);
        if (r.flags[3]) begin
            m_pplv = m_plv;
            m_pie = m_ie;
            m_plv = KERNEL;
            m_ie = 1'b0;
            m_era = pc;
            m_ecode = r.ecode;
            m_known[3:2] = 2'b11;
            if (r.flags[2]) begin
                m_da = 1'b1;   // refill handler runs untranslated
                m_pg = 1'b0;
            end
            if (r.flags[1]) begin
                m_badv = bad;
                m_known[1] = 1'b1;
            end
            if (r.flags[0]) begin
                m_vppn = bad[31:13];
                m_known[0] = 1'b1;
            end
        end
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    initial begin
        row_t r;
        logic [31:0] pc;
        logic [31:0] bad;
        commit_valid = 1'b0;
        commit_pc = '0;
        excp_valid = 1'b0;
        excp_code = INT;
        excp_badv = '0;
        csr_we = 1'b0;
        csr_addr = CRMD;
        csr_wdata = '0;
        hwi = '0;
        ti = 1'b0;
        swi_set = '0;
        swi_clr = '0;
        ti_clr = 1'b0;
        chk_comb = 1'b0;
        chk_regs = 1'b0;
        exp_redir = 1'b0;
        exp_wake = 1'b0;
        exp_rpc = '0;
        exp_int = '0;
        cur_name = '0;
        // reset state: kernel, interrupts off, direct addressing
        {m_plv, m_pplv, m_ie, m_pie, m_da, m_pg} = 8'b0000_0010;
        m_lie = '0;
        m_ecode = '0;
        m_era = '0;
        m_badv = '0;
        m_vppn = '0;
        m_known = '0;
        m_eentry = `EXCP_EENTRY_RST;
        m_tlbrentry = `EXCP_TLBRENTRY_RST;
        build_table();
        cycle_limit = table_q.size() * ROW_CYCLES + RST_CYCLES + 20;
        wait (rst_n === 1'b1);
        foreach (table_q[i]) begin
            r = table_q[i];
            pc = next_word() & 32'hffff_fffc;
            bad = next_word();
            @(negedge clk);
            chk_regs = 1'b0;
            cur_name = r.name;
            csr_we = r.wr_en;
            csr_addr = r.addr;
            csr_wdata = r.data;
            hwi = r.set[9:2];
            ti = r.set[11];
            swi_set = r.set[1:0];
            swi_clr = r.clr[1:0];
            ti_clr = r.clr[11];
            model_write(r);
            @(negedge clk);
            csr_we = 1'b0;
            hwi = '0;
            ti = 1'b0;
            swi_set = '0;
            swi_clr = '0;
            ti_clr = 1'b0;
            @(negedge clk);   // pending bits need two edges to reach int_status
            commit_valid = r.cmt[1];
            excp_valid = r.cmt[0];
            excp_code = r.code;
            commit_pc = pc;
            excp_badv = bad;
            exp_wake = r.flags[4];
            exp_redir = r.flags[3];
            exp_rpc = r.flags[2] ? m_tlbrentry : m_eentry;
            exp_int = r.ints;
            chk_comb = 1'b1;
            @(negedge clk);
            commit_valid = 1'b0;
            excp_valid = 1'b0;
            chk_comb = 1'b0;
            model_commit(r, pc, bad);
            chk_regs = 1'b1;
        end
        @(negedge clk);
        chk_regs = 1'b0;
        $display("tests passed %0d failed %0d", pass_count, fail_count);
        if (fail_count == 0 && pass_count == table_q.size()) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
+incdir+common
common/excp_pkg.sv
design/int_pending.sv
exception/excp_decode.sv
exception/excp_commit.sv
csr/csr_file.sv
design/excp_unit_top.sv
verification/tb_clock_gen.sv
verification/tb_checker.sv
verification/tb_excp_unit.sv

/* Bender.yml */
package:
  name: excp_unit

export_include_dirs:
  - common

sources:
  - common/excp_pkg.sv
  - design/int_pending.sv
  - exception/excp_decode.sv
  - exception/excp_commit.sv
  - csr/csr_file.sv
  - design/excp_unit_top.sv
  - target: test
    files:
      - verification/tb_clock_gen.sv
      - verification/tb_checker.sv
      - verification/tb_excp_unit.sv
